// File: rtl/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int xlen       = 32;
    localparam int hist_w     = 16;  // global history length
    localparam int num_tagged = 2;
    localparam int tt_idx_w   = 8;   // 256 entries per tagged table
    localparam int tt_tag_w   = 10;
    localparam int bm_idx_w   = 9;   // 512 bimodal entries
    localparam int btb_idx_w  = 8;
    localparam int btb_tag_w  = 22;  // pc[31:10]

    // 2-bit saturating counter, msb is the taken prediction
    typedef logic [1:0] ctr_t;

    typedef enum logic [1:0] {
        prov_bimodal = 2'd0,
        prov_t0      = 2'd1,
        prov_t1      = 2'd2
    } provider_e;

    typedef enum logic [6:0] {
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    typedef enum logic [1:0] {
        upd_idle  = 2'd0,
        upd_train = 2'd1,  // provider right, step counter
        upd_reset = 2'd2,  // provider wrong, strong counter
        upd_alloc = 2'd3   // bimodal wrong, allocation candidate
    } upd_mode_e;

    typedef struct packed {
        logic [tt_idx_w-1:0] idx;
        logic [tt_tag_w-1:0] tag;
    } tt_lookup_t;

    typedef struct packed {
        logic [tt_idx_w-1:0] idx;
        logic [tt_tag_w-1:0] tag;
        upd_mode_e           mode;
        logic                taken;
    } tt_update_t;

    // feedback from execute, one resolved branch per cycle
    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   pc;
        logic              taken;
        logic              mispredict;
        logic [xlen-1:0]   target;
        logic [hist_w-1:0] history;  // as reported at prediction
        provider_e         provider;
    } bpu_update_t;

    typedef struct packed {
        logic              is_ctrl;
        logic              taken;
        logic [xlen-1:0]   target;
        provider_e         provider;
        logic [hist_w-1:0] history;
    } bpu_pred_t;

    function automatic ctr_t ctr_step(ctr_t ctr, logic taken);
        if (taken && ctr != 2'b11) begin
            return ctr + 2'd1;
        end
        if (!taken && ctr != 2'b00) begin
            return ctr - 2'd1;
        end
        return ctr;  // saturated
    endfunction

endpackage

`default_nettype wire

// File: rtl/history_hash.sv
`timescale 1ns/10ps
`default_nettype none

module history_hash (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [bpu_pkg::xlen-1:0]                                if_pc_i,
    input  bpu_pkg::bpu_update_t                                    upd_i,
    output bpu_pkg::tt_lookup_t [bpu_pkg::num_tagged-1:0]           lookup_o,
    output bpu_pkg::tt_update_t [bpu_pkg::num_tagged-1:0]           update_o,
    output logic [bpu_pkg::hist_w-1:0]                              history_o
);

    logic [bpu_pkg::hist_w-1:0] ghist_q;

    // shift in the resolved direction of every valid update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (upd_i.valid) begin
            ghist_q <= {ghist_q[bpu_pkg::hist_w-2:0], upd_i.taken};
        end
    end

    assign history_o = ghist_q;

    // table 1 sees the older half of the history in its index
    function automatic bpu_pkg::tt_lookup_t tt_hash(
        input int                         tbl,
        input logic [bpu_pkg::xlen-1:0]   pc,
        input logic [bpu_pkg::hist_w-1:0] hist
    );
        bpu_pkg::tt_lookup_t h;
        if (tbl == 0) begin
            h.idx = pc[7:0] ^ hist[7:0];
            h.tag = pc[17:8] ^ hist[15:6];
        end else begin
            h.idx = pc[7:0] ^ hist[15:8];
            h.tag = pc[17:8] ^ {{(bpu_pkg::tt_tag_w-8){1'b0}}, hist[7:0]};
        end
        return h;
    endfunction

    for (genvar t = 0; t < bpu_pkg::num_tagged; t++) begin : g_tbl
        localparam bpu_pkg::provider_e own_prov = bpu_pkg::provider_e'(t + 1);

        bpu_pkg::tt_lookup_t upd_hash;
        bpu_pkg::upd_mode_e  mode;

        assign lookup_o[t] = tt_hash(t, if_pc_i, ghist_q);
        assign upd_hash    = tt_hash(t, upd_i.pc, upd_i.history);  // history at prediction

        always_comb begin
            mode = bpu_pkg::upd_idle;
            if (upd_i.valid) begin
                if (upd_i.provider == own_prov) begin
                    mode = upd_i.mispredict ? bpu_pkg::upd_reset : bpu_pkg::upd_train;
                end else if (upd_i.mispredict && upd_i.provider == bpu_pkg::prov_bimodal) begin
                    mode = bpu_pkg::upd_alloc;  // all tables, chain picks one
                end
            end
        end

        assign update_o[t] = '{
            idx:   upd_hash.idx,
            tag:   upd_hash.tag,
            mode:  mode,
            taken: upd_i.taken
        };
    end

endmodule

`default_nettype wire

// File: rtl/tagged_table.sv
`timescale 1ns/10ps
`default_nettype none

module tagged_table #(
    parameter int partial_tag_bits = 6
) (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::tt_lookup_t lookup_i,
    input  bpu_pkg::tt_update_t update_i,
    input  logic                alloc_pass_i,
    output logic                alloc_pass_o,
    output logic                hit_o,
    output bpu_pkg::ctr_t       ctr_o
);

    localparam int entries = 1 << bpu_pkg::tt_idx_w;
    localparam int tag_msb = bpu_pkg::tt_tag_w - 1;

    logic [tag_msb:0] tag_q [entries];
    bpu_pkg::ctr_t    ctr_q [entries];
    logic             upd_tag_match;

    // lookup compares only the upper tag bits
    assign hit_o = tag_q[lookup_i.idx][tag_msb -: partial_tag_bits]
                   == lookup_i.tag[tag_msb -: partial_tag_bits];
    assign ctr_o = ctr_q[lookup_i.idx];

    // allocation uses the full tag
    assign upd_tag_match = tag_q[update_i.idx] == update_i.tag;

    // entry already present here, offer the slot to the next shorter table
    assign alloc_pass_o = alloc_pass_i & upd_tag_match;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                tag_q[i] <= '0;
                ctr_q[i] <= 2'b01;  // weak not-taken
            end
        end else begin
            case (update_i.mode)
                bpu_pkg::upd_train: begin
                    ctr_q[update_i.idx] <= bpu_pkg::ctr_step(ctr_q[update_i.idx],
                                                             update_i.taken);
                end
                bpu_pkg::upd_reset: begin
                    ctr_q[update_i.idx] <= update_i.taken ? 2'b11 : 2'b00;
                end
                bpu_pkg::upd_alloc: begin
                    if (alloc_pass_i && !upd_tag_match) begin
                        tag_q[update_i.idx] <= update_i.tag;
                        ctr_q[update_i.idx] <= update_i.taken ? 2'b10 : 2'b01;  // weak
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/bimodal_table.sv
`timescale 1ns/10ps
`default_nettype none

module bimodal_table (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] if_pc_i,
    input  bpu_pkg::bpu_update_t     upd_i,
    output bpu_pkg::ctr_t            ctr_o
);

    localparam int entries = 1 << bpu_pkg::bm_idx_w;

    bpu_pkg::ctr_t                ctr_q [entries];
    logic [bpu_pkg::bm_idx_w-1:0] rd_idx;
    logic [bpu_pkg::bm_idx_w-1:0] wr_idx;

    // pc[9:1] keeps compressed neighbours apart
    assign rd_idx = if_pc_i[bpu_pkg::bm_idx_w:1];
    assign wr_idx = upd_i.pc[bpu_pkg::bm_idx_w:1];

    assign ctr_o = ctr_q[rd_idx];

    // trained on every resolved branch, whoever provided
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                ctr_q[i] <= 2'b01;
            end
        end else if (upd_i.valid) begin
            ctr_q[wr_idx] <= bpu_pkg::ctr_step(ctr_q[wr_idx], upd_i.taken);
        end
    end

endmodule

`default_nettype wire

// File: rtl/btb.sv
`timescale 1ns/10ps
`default_nettype none

module btb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] if_pc_i,
    input  bpu_pkg::bpu_update_t     upd_i,
    output logic                     hit_o,
    output logic [bpu_pkg::xlen-1:0] target_o
);

    localparam int entries = 1 << bpu_pkg::btb_idx_w;
    localparam int xmsb    = bpu_pkg::xlen - 1;

    logic                          valid_q  [entries];
    logic [bpu_pkg::btb_tag_w-1:0] tag_q    [entries];
    logic [xmsb:0]                 target_q [entries];

    logic [bpu_pkg::btb_idx_w-1:0] rd_idx;
    logic [bpu_pkg::btb_idx_w-1:0] wr_idx;
    logic [bpu_pkg::btb_tag_w-1:0] rd_tag;
    logic [bpu_pkg::btb_tag_w-1:0] wr_tag;

    assign rd_idx = if_pc_i[bpu_pkg::btb_idx_w+1:2];   // pc[9:2]
    assign wr_idx = upd_i.pc[bpu_pkg::btb_idx_w+1:2];
    assign rd_tag = if_pc_i[xmsb -: bpu_pkg::btb_tag_w];  // pc[31:10]
    assign wr_tag = upd_i.pc[xmsb -: bpu_pkg::btb_tag_w];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_i.valid && upd_i.taken) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target only matter once valid is set
    always_ff @(posedge clk) begin
        if (upd_i.valid && upd_i.taken) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd_i.target;
        end
    end

endmodule

`default_nettype wire

// File: rtl/provider_select.sv
`timescale 1ns/10ps
`default_nettype none

module provider_select (
    input  logic [bpu_pkg::xlen-1:0]                    if_pc_i,
    input  logic [bpu_pkg::xlen-1:0]                    if_inst_i,
    input  logic [bpu_pkg::hist_w-1:0]                  history_i,
    input  logic [bpu_pkg::num_tagged-1:0]              tt_hit_i,
    input  bpu_pkg::ctr_t [bpu_pkg::num_tagged-1:0]     tt_ctr_i,
    input  bpu_pkg::ctr_t                               bm_ctr_i,
    input  logic                                        btb_hit_i,
    input  logic [bpu_pkg::xlen-1:0]                    btb_target_i,
    output bpu_pkg::bpu_pred_t                          pred_o
);

    bpu_pkg::opcode_e         opc;
    logic                     is_branch;
    logic                     is_jal;
    logic                     is_jalr;
    bpu_pkg::provider_e       dir_prov;
    logic                     dir_taken;
    logic                     pred_taken;
    logic [bpu_pkg::xlen-1:0] b_imm;
    logic [bpu_pkg::xlen-1:0] j_imm;
    logic [bpu_pkg::xlen-1:0] jump_pc;
    logic [bpu_pkg::xlen-1:0] seq_pc;

    assign opc       = bpu_pkg::opcode_e'(if_inst_i[6:0]);
    assign is_branch = (opc == bpu_pkg::opc_branch);
    assign is_jal    = (opc == bpu_pkg::opc_jal);
    assign is_jalr   = (opc == bpu_pkg::opc_jalr);  // no return stack, never taken

    assign b_imm = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};
    assign j_imm = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};

    // later tables have longer history, so the last hit wins
    always_comb begin
        dir_prov  = bpu_pkg::prov_bimodal;
        dir_taken = bm_ctr_i[1];
        for (int t = 0; t < bpu_pkg::num_tagged; t++) begin
            if (tt_hit_i[t]) begin
                dir_prov  = bpu_pkg::provider_e'(t + 1);
                dir_taken = tt_ctr_i[t][1];
            end
        end
    end

    assign pred_taken = is_jal | (is_branch & dir_taken);

    assign seq_pc  = if_pc_i + 32'd4;
    assign jump_pc = if_pc_i + (is_jal ? j_imm : b_imm);  // fallback on btb miss

    always_comb begin
        pred_o.is_ctrl  = is_branch | is_jal | is_jalr;
        pred_o.taken    = pred_taken;
        pred_o.provider = is_branch ? dir_prov : bpu_pkg::prov_bimodal;
        pred_o.history  = history_i;
        if (!pred_taken) begin
            pred_o.target = seq_pc;
        end else if (btb_hit_i) begin
            pred_o.target = btb_target_i;
        end else begin
            pred_o.target = jump_pc;
        end
    end

endmodule

`default_nettype wire

// File: rtl/bpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module bpu_top #(
    parameter int partial_tag_bits = 6  // 1 to tt_tag_w
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] if_pc_i,
    input  logic [bpu_pkg::xlen-1:0] if_inst_i,
    input  bpu_pkg::bpu_update_t     upd_i,
    output bpu_pkg::bpu_pred_t       pred_o
);

    bpu_pkg::tt_lookup_t [bpu_pkg::num_tagged-1:0] tt_lookup;
    bpu_pkg::tt_update_t [bpu_pkg::num_tagged-1:0] tt_update;
    logic [bpu_pkg::num_tagged-1:0]                tt_hit;
    bpu_pkg::ctr_t [bpu_pkg::num_tagged-1:0]       tt_ctr;
    logic [bpu_pkg::num_tagged:0]                  alloc_chain;
    logic [bpu_pkg::hist_w-1:0]                    history;
    bpu_pkg::ctr_t                                 bm_ctr;
    logic                                          btb_hit;
    logic [bpu_pkg::xlen-1:0]                      btb_target;

    history_hash u_history_hash (
        .clk       (clk),
        .rst       (rst),
        .if_pc_i   (if_pc_i),
        .upd_i     (upd_i),
        .lookup_o  (tt_lookup),
        .update_o  (tt_update),
        .history_o (history)
    );

    // longest history table always gets first offer
    assign alloc_chain[bpu_pkg::num_tagged] = 1'b1;

    for (genvar t = 0; t < bpu_pkg::num_tagged; t++) begin : g_tagged
        tagged_table #(
            .partial_tag_bits (partial_tag_bits)
        ) u_tagged_table (
            .clk          (clk),
            .rst          (rst),
            .lookup_i     (tt_lookup[t]),
            .update_i     (tt_update[t]),
            .alloc_pass_i (alloc_chain[t+1]),
            .alloc_pass_o (alloc_chain[t]),
            .hit_o        (tt_hit[t]),
            .ctr_o        (tt_ctr[t])
        );
    end

    bimodal_table u_bimodal_table (
        .clk     (clk),
        .rst     (rst),
        .if_pc_i (if_pc_i),
        .upd_i   (upd_i),
        .ctr_o   (bm_ctr)
    );

    btb u_btb (
        .clk      (clk),
        .rst      (rst),
        .if_pc_i  (if_pc_i),
        .upd_i    (upd_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    provider_select u_provider_select (
        .if_pc_i      (if_pc_i),
        .if_inst_i    (if_inst_i),
        .history_i    (history),
        .tt_hit_i     (tt_hit),
        .tt_ctr_i     (tt_ctr),
        .bm_ctr_i     (bm_ctr),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pred_o       (pred_o)
    );

endmodule

`default_nettype wire

// File: tests/bpu_sva.sv
`timescale 1ns/10ps
`default_nettype none

module bpu_sva (
    input logic                     clk,
    input logic                     rst,
    input logic [bpu_pkg::xlen-1:0] if_pc_i,
    input logic [bpu_pkg::xlen-1:0] if_inst_i,
    input bpu_pkg::bpu_update_t     upd_i,
    input bpu_pkg::bpu_pred_t       pred_o
);

    localparam int hmsb = bpu_pkg::hist_w - 1;

    logic ctrl_opc;

    assign ctrl_opc = if_inst_i[6:0] == bpu_pkg::opc_branch
                      || if_inst_i[6:0] == bpu_pkg::opc_jal
                      || if_inst_i[6:0] == bpu_pkg::opc_jalr;

    // fall-through target on every not-taken prediction
    not_taken_seq_target: assert property (
        @(posedge clk) disable iff (rst)
        !pred_o.taken |-> pred_o.target == if_pc_i + 32'd4
    ) else $error("not-taken prediction with a target other than pc+4");

    non_ctrl_flag_low: assert property (
        @(posedge clk) disable iff (rst)
        !ctrl_opc |-> !pred_o.is_ctrl
    ) else $error("is_ctrl set for a non-control instruction");

    hist_shift_one: assert property (
        @(posedge clk) disable iff (rst)
        upd_i.valid |=> pred_o.history == {$past(pred_o.history[hmsb-1:0]), $past(upd_i.taken)}
    ) else $error("history did not shift in the resolved direction");

    hist_hold: assert property (
        @(posedge clk) disable iff (rst)
        !upd_i.valid |=> $stable(pred_o.history)
    ) else $error("history changed without a valid update");

endmodule

bind bpu_top bpu_sva u_bpu_sva (
    .clk       (clk),
    .rst       (rst),
    .if_pc_i   (if_pc_i),
    .if_inst_i (if_inst_i),
    .upd_i     (upd_i),
    .pred_o    (pred_o)
);

`default_nettype wire

// File: tests/tb_bpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bpu;

    logic                 clk;
    logic                 rst;
    logic [31:0]          if_pc;
    logic [31:0]          if_inst;
    bpu_pkg::bpu_update_t upd;
    bpu_pkg::bpu_pred_t   pred;

    logic [31:0] lfsr_q = 32'h5797_17f8;
    logic [15:0] hist_model;
    logic        btb_v   [256];
    logic [31:0] btb_pc  [256];  // full pc kept for the 31:10 tag compare
    logic [31:0] btb_tgt [256];
    int          checks;
    int          errors;

    bpu_top #(
        .partial_tag_bits (6)
    ) u_bpu_top (
        .clk       (clk),
        .rst       (rst),
        .if_pc_i   (if_pc),
        .if_inst_i (if_inst),
        .upd_i     (upd),
        .pred_o    (pred)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    initial begin
        repeat (5000) @(posedge clk);
        $display("timeout: simulation ran past its cycle limit");
        $display("Testbench failed");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] imm_b(input logic [31:0] inst);
        logic [12:0] imm;
        imm = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        return {{19{imm[12]}}, imm};
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] inst);
        logic [20:0] imm;
        imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        return {{11{imm[20]}}, imm};
    endfunction

    // taken target from the btb model or the immediate
    function automatic logic [31:0] taken_target(input logic [31:0] pc, input logic [31:0] inst);
        logic [7:0] i;
        i = pc[9:2];
        if (btb_v[i] && btb_pc[i][31:10] == pc[31:10]) begin
            return btb_tgt[i];
        end
        if (inst[6:0] == 7'h6f) begin
            return pc + imm_j(inst);
        end
        return pc + imm_b(inst);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic random_pc(output logic [31:0] pc);
        logic [31:0] r;
        take_bits(30, r);
        pc = {r[29:0], 2'b00} | 32'h0002_0000;  // bit 17 keeps tags off reset entries
    endtask

    task automatic random_inst(input logic [6:0] opc, output logic [31:0] inst);
        logic [31:0] r;
        take_bits(25, r);
        inst = {r[24:0], opc};
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        upd = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        hist_model = '0;
        for (int i = 0; i < 256; i++) begin
            btb_v[i] = 1'b0;
        end
    endtask

    task automatic predict(input logic [31:0] pc, input logic [31:0] inst);
        @(posedge clk);
        #1;
        if_pc = pc;
        if_inst = inst;
        upd = '0;
        #2;
        check_value("history", 32'(hist_model), 32'(pred.history));
    endtask

    // feedback one cycle after the prediction it belongs to
    task automatic send_update(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target, input bpu_pkg::bpu_pred_t pr);
        logic [7:0] i;
        @(posedge clk);
        #1;
        upd.valid = 1'b1;
        upd.pc = pc;
        upd.taken = taken;
        upd.target = target;
        upd.mispredict = (pr.taken != taken) || (taken && pr.target != target);
        upd.history = pr.history;
        upd.provider = pr.provider;
        hist_model = {hist_model[14:0], taken};
        if (taken) begin
            i = pc[9:2];
            btb_v[i] = 1'b1;
            btb_pc[i] = pc;
            btb_tgt[i] = target;
        end
    endtask

    task automatic report_test(input string name, input int chk0, input int err0);
        $display("test %s finished: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        logic [31:0]        pc;
        logic [31:0]        pc2;
        logic [31:0]        inst;
        logic [31:0]        tgt;
        logic [31:0]        r;
        logic               exp_ctrl;
        bpu_pkg::bpu_pred_t saved;
        int                 chk0;
        int                 err0;
        int                 n;

        rst = 1'b1;
        if_pc = '0;
        if_inst = 32'h0000_0013;  // nop
        upd = '0;
        hist_model = '0;
        checks = 0;
        errors = 0;
        apply_reset();

        chk0 = checks;
        err0 = errors;
        for (int k = 0; k < 40; k++) begin
            random_pc(pc);
            take_bits(2, r);
            if (r[1:0] == 2'd0) begin
                random_inst(7'h63, inst);
            end else if (r[1:0] == 2'd1) begin
                random_inst(7'h67, inst);
            end else begin
                take_bits(32, inst);
                if (inst[6:0] == 7'h6f) begin
                    inst[3] = 1'b0;  // jal becomes jalr
                end
            end
            exp_ctrl = inst[6:0] == 7'h63 || inst[6:0] == 7'h6f || inst[6:0] == 7'h67;
            predict(pc, inst);
            check_value("reset_state taken", 32'd0, 32'(pred.taken));
            check_value("reset_state target", pc + 32'd4, pred.target);
            check_value("reset_state is_ctrl", 32'(exp_ctrl), 32'(pred.is_ctrl));
            if (inst[6:0] == 7'h63) begin
                check_value("reset_state provider", 32'(bpu_pkg::prov_bimodal),
                            32'(pred.provider));
            end
        end
        report_test("reset_state", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (int k = 0; k < 16; k++) begin
            random_pc(pc);
            random_inst(7'h6f, inst);
            predict(pc, inst);
            check_value("jal taken", 32'd1, 32'(pred.taken));
            check_value("jal target", taken_target(pc, inst), pred.target);
            check_value("jal is_ctrl", 32'd1, 32'(pred.is_ctrl));
            random_pc(pc);
            random_inst(7'h67, inst);
            predict(pc, inst);
            check_value("jalr taken", 32'd0, 32'(pred.taken));
            check_value("jalr target", pc + 32'd4, pred.target);
        end
        report_test("jal_jalr", chk0, err0);

        chk0 = checks;
        err0 = errors;
        apply_reset();
        random_pc(pc);
        random_inst(7'h63, inst);
        random_pc(tgt);
        repeat (2) begin
            predict(pc, inst);
            saved = pred;
            send_update(pc, 1'b1, tgt, saved);
        end
        predict(pc, inst);
        check_value("direction taken", 32'd1, 32'(pred.taken));
        check_value("direction target", taken_target(pc, inst), pred.target);
        // the first bimodal mispredict allocates into table 1 which then hits
        check_value("direction provider", 32'(bpu_pkg::prov_t1), 32'(pred.provider));
        n = 0;
        while (pred.taken && n < 4) begin
            saved = pred;
            send_update(pc, 1'b0, pc + 32'd4, saved);
            predict(pc, inst);
            n++;
        end
        assert (!pred.taken) else begin
            errors++;
            $display("direction: branch still predicted taken after %0d not-taken updates", n);
        end
        report_test("direction", chk0, err0);

        chk0 = checks;
        err0 = errors;
        apply_reset();
        random_pc(pc);
        random_inst(7'h63, inst);
        random_pc(tgt);
        repeat (2) begin
            predict(pc, inst);
            saved = pred;
            send_update(pc, 1'b1, tgt, saved);
        end
        predict(pc, inst);
        check_value("btb hit taken", 32'd1, 32'(pred.taken));
        check_value("btb hit target", tgt, pred.target);
        pc2 = {~pc[31:18], pc[17:0]};  // other btb tag on the same table indices
        predict(pc2, inst);
        check_value("btb miss taken", 32'd1, 32'(pred.taken));
        check_value("btb miss target", pc2 + imm_b(inst), pred.target);
        report_test("btb", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (int k = 0; k < 200; k++) begin
            take_bits(3, r);
            @(posedge clk);
            #1;
            upd = '0;
            upd.valid = r[0] | r[1];  // gaps about one cycle in four
            upd.taken = r[2];
            upd.provider = bpu_pkg::prov_bimodal;
            #2;
            check_value("history shift", 32'(hist_model), 32'(pred.history));
            if (upd.valid) begin
                hist_model = {hist_model[14:0], upd.taken};
            end
        end
        @(posedge clk);
        #1;
        upd = '0;
        report_test("history", chk0, err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/bpu_pkg.sv
rtl/history_hash.sv
rtl/tagged_table.sv
rtl/bimodal_table.sv
rtl/btb.sv
rtl/provider_select.sv
rtl/bpu_top.sv
tests/bpu_sva.sv
tests/tb_bpu.sv

// File: Makefile
TOP := tb_bpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
